// ==== verilog/mips_cpu_params.svh ====
`ifndef MIPS_CPU_PARAMS_SVH
`define MIPS_CPU_PARAMS_SVH

// Data and address width of the core
`define MIPS_DATA_WIDTH 32

`define MIPS_REG_COUNT 32

// Boot address in kseg1 ROM
`define MIPS_RESET_VECTOR 32'hBFC0_0000

`endif

// ==== verilog/mips_cpu_pkg.sv ====
package mips_cpu_pkg;

    typedef enum logic [2:0] {
        s_halted = 3'd0,
        s_fetch  = 3'd1,
        s_decode = 3'd2,
        s_exec1  = 3'd3,
        s_exec2  = 3'd4
    } state_t;

    typedef enum logic [3:0] {
        alu_add    = 4'd0,
        alu_pass_b = 4'd1,
        alu_func   = 4'd2,   // Op taken from fncode
        alu_eq     = 4'd3,
        alu_gez    = 4'd4,
        alu_gtz    = 4'd5,
        alu_lez    = 4'd6,
        alu_ltz    = 4'd7,
        alu_ne     = 4'd8,
        alu_pass_a = 4'd9,
        alu_and    = 4'd10,
        alu_or     = 4'd11,
        alu_xor    = 4'd12,
        alu_slt    = 4'd13,
        alu_sltu   = 4'd14
    } aluop_t;

endpackage

// ==== verilog/mips_cpu_sequencer.sv ====
`timescale 1ns/100ps

module mips_cpu_sequencer (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 waitrequest,
    input  logic                 two_cycle,
    input  logic                 pc_zero,
    output mips_cpu_pkg::state_t state
);
    import mips_cpu_pkg::*;

    state_t state_next;
    state_t fetch_or_halt;

    always_comb begin
        fetch_or_halt = pc_zero ? s_halted : s_fetch;   // Jump to 0 ends the program
        case (state)
            s_fetch: begin
                state_next = waitrequest ? s_fetch : s_decode;
            end
            s_decode: begin
                state_next = s_exec1;
            end
            s_exec1: begin
                if (waitrequest) begin
                    state_next = s_exec1;   // Load or store still on the bus
                end else if (two_cycle) begin
                    state_next = s_exec2;
                end else begin
                    state_next = fetch_or_halt;
                end
            end
            s_exec2: begin
                state_next = fetch_or_halt;
            end
            default: begin
                state_next = s_halted;   // Stays here until reset
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= s_fetch;
        end else begin
            state <= state_next;
        end
    end

endmodule

// ==== verilog/mips_cpu_controller.sv ====
`timescale 1ns/100ps

module mips_cpu_controller (
    input  logic [5:0]           opcode,
    input  logic [5:0]           fncode,
    input  logic [4:0]           regimm,
    input  logic [1:0]           memoryadress,
    input  mips_cpu_pkg::state_t state,
    input  logic                 waitrequest,
    output logic [1:0]           regdst,
    output logic [1:0]           loadtype,
    output logic                 regwrite,
    output logic                 iord,
    output logic                 irwrite,
    output logic                 pcwrite,
    output logic [1:0]           pcsource,
    output logic                 pcwritecond,
    output logic                 jump,
    output logic                 jumpconen,
    output logic                 memread,
    output logic                 memwrite,
    output logic [3:0]           byteenable,
    output logic                 memtoreg,
    output mips_cpu_pkg::aluop_t aluop,
    output logic                 hilowrite,
    output logic                 alusrca,
    output logic [2:0]           alusrcb,
    output logic                 aluouten,
    output logic                 two_cycle
);
    import mips_cpu_pkg::*;

    logic exec1;
    logic exec2;

    assign exec1 = (state == s_exec1);
    assign exec2 = (state == s_exec2);

    always_comb begin
        regdst      = 2'd0;   // 0 rt, 1 rd, 2 r31
        loadtype    = 2'd0;   // 0 zero ext, 1 sign ext, 2 LUI
        regwrite    = 1'b0;
        iord        = 1'b0;
        irwrite     = 1'b0;
        pcwrite     = 1'b0;
        pcsource    = 2'd0;   // 0 ALU, 1 ALUOut, 2 J target, 3 rs
        pcwritecond = 1'b0;
        jump        = 1'b0;
        jumpconen   = 1'b0;
        memread     = 1'b0;
        memwrite    = 1'b0;
        byteenable  = 4'b0000;
        memtoreg    = 1'b0;
        aluop       = alu_add;
        hilowrite   = 1'b0;
        alusrca     = 1'b0;   // 0 PC, 1 rs
        alusrcb     = 3'd0;   // 0 rt, 1 four, 2 sext, 3 branch offset, 4 zext, 5 HI/LO
        aluouten    = 1'b0;
        two_cycle   = 1'b0;

        case (state)
            s_fetch: begin
                irwrite    = 1'b1;
                memread    = 1'b1;
                byteenable = 4'b1111;
                pcwrite    = !waitrequest;
                jumpconen  = !waitrequest;   // Apply pending delay-slot target
                alusrcb    = 3'd1;
            end
            s_decode: begin
                alusrcb  = 3'd3;   // Branch target into ALUOut
                aluouten = 1'b1;
            end
            s_exec1, s_exec2: begin
                case (opcode)
                    6'h00: begin
                        case (fncode)
                            6'h00, 6'h02, 6'h03, 6'h04, 6'h06, 6'h07,
                            6'h21, 6'h23, 6'h24, 6'h25, 6'h26, 6'h2a, 6'h2b: begin
                                regdst   = 2'd1;
                                regwrite = 1'b1;
                                aluop    = alu_func;
                                alusrca  = 1'b1;
                            end
                            6'h08, 6'h09: begin   // JR, JALR
                                pcsource = 2'd3;
                                jump     = 1'b1;
                                regdst   = 2'd1;
                                regwrite = fncode[0];
                                alusrcb  = 3'd1;   // Link is PC + 4 past the slot
                            end
                            6'h10, 6'h12: begin
                                regdst   = 2'd1;
                                regwrite = 1'b1;
                                aluop    = alu_pass_b;
                                alusrcb  = 3'd5;
                            end
                            6'h11, 6'h13, 6'h18, 6'h19, 6'h1a, 6'h1b: begin
                                hilowrite = 1'b1;   // Mult/div only move rs
                                aluop     = alu_pass_a;
                                alusrca   = 1'b1;
                            end
                            default: begin
                            end
                        endcase
                    end
                    6'h01: begin
                        pcsource = 2'd1;
                        case (regimm)
                            5'h00, 5'h01: begin
                                pcwritecond = 1'b1;
                                alusrca     = 1'b1;
                                aluop       = regimm[0] ? alu_gez : alu_ltz;
                            end
                            5'h10, 5'h11: begin   // Link first, then test rs
                                two_cycle   = 1'b1;
                                regdst      = 2'd2;
                                regwrite    = exec1;
                                alusrcb     = exec1 ? 3'd1 : 3'd0;
                                pcwritecond = exec2;
                                alusrca     = exec2;
                                if (exec2) begin
                                    aluop = regimm[0] ? alu_gez : alu_ltz;
                                end
                            end
                            default: begin
                            end
                        endcase
                    end
                    6'h02, 6'h03: begin   // J, JAL
                        pcsource = 2'd2;
                        jump     = 1'b1;
                        regdst   = 2'd2;
                        regwrite = opcode[0];
                        alusrcb  = 3'd1;
                    end
                    6'h04, 6'h05, 6'h06, 6'h07: begin
                        pcsource    = 2'd1;
                        pcwritecond = 1'b1;
                        alusrca     = 1'b1;
                        aluop       = opcode[1:0] == 2'b00 ? alu_eq :
                                      opcode[1:0] == 2'b01 ? alu_ne :
                                      opcode[1:0] == 2'b10 ? alu_lez : alu_gtz;
                    end
                    6'h09: begin
                        regwrite = 1'b1;
                        alusrca  = 1'b1;
                        alusrcb  = 3'd2;
                    end
                    6'h0a, 6'h0b, 6'h0c, 6'h0d, 6'h0e: begin
                        regwrite = 1'b1;
                        alusrca  = 1'b1;
                        alusrcb  = opcode[2] ? 3'd4 : 3'd2;   // Logic ops zero extend
                        aluop    = opcode == 6'h0a ? alu_slt :
                                   opcode == 6'h0b ? alu_sltu :
                                   opcode == 6'h0c ? alu_and :
                                   opcode == 6'h0d ? alu_or : alu_xor;
                    end
                    6'h0f: begin
                        regwrite = 1'b1;
                        loadtype = 2'd2;
                    end
                    6'h20, 6'h21, 6'h23, 6'h24, 6'h25: begin
                        two_cycle  = 1'b1;
                        iord       = 1'b1;
                        alusrca    = 1'b1;
                        alusrcb    = 3'd2;
                        aluouten   = exec1;   // Keep address for lane select
                        memread    = exec1;
                        byteenable = exec1 ? 4'b1111 : 4'b0000;
                        regwrite   = exec2;
                        memtoreg   = 1'b1;
                        loadtype   = opcode[2] ? 2'd0 : 2'd1;
                    end
                    6'h28, 6'h29, 6'h2b: begin
                        iord       = 1'b1;
                        memwrite   = 1'b1;
                        alusrca    = 1'b1;
                        alusrcb    = 3'd2;
                        byteenable = opcode == 6'h2b ? 4'b1111 :
                                     opcode == 6'h29 ? 4'b0011 << memoryadress :
                                     4'b0001 << memoryadress;
                    end
                    default: begin
                    end
                endcase
            end
            default: begin
            end
        endcase
    end

endmodule

// ==== verilog/mips_cpu_alu.sv ====
`timescale 1ns/100ps
`include "mips_cpu_params.svh"

module mips_cpu_alu (
    input  logic [`MIPS_DATA_WIDTH-1:0] a,
    input  logic [`MIPS_DATA_WIDTH-1:0] b,
    input  logic [4:0]                  shamt,
    input  logic [5:0]                  fncode,
    input  mips_cpu_pkg::aluop_t        aluop,
    output logic [`MIPS_DATA_WIDTH-1:0] alu_result,
    output logic                        cond
);
    import mips_cpu_pkg::*;

    localparam int W = `MIPS_DATA_WIDTH;

    logic signed [W-1:0] a_s;
    logic signed [W-1:0] b_s;
    logic [W-1:0]        slt_val;
    logic [W-1:0]        sltu_val;
    logic [W-1:0]        func_result;

    assign a_s = a;
    assign b_s = b;
    assign slt_val = {{(W-1){1'b0}}, a_s < b_s};
    assign sltu_val = {{(W-1){1'b0}}, a < b};

    always_comb begin
        case (fncode)
            6'h00: func_result = b << shamt;
            6'h02: func_result = b >> shamt;
            6'h03: func_result = b_s >>> shamt;
            6'h04: func_result = b << a[4:0];   // Variable shifts use rs
            6'h06: func_result = b >> a[4:0];
            6'h07: func_result = b_s >>> a[4:0];
            6'h23: func_result = a - b;
            6'h24: func_result = a & b;
            6'h25: func_result = a | b;
            6'h26: func_result = a ^ b;
            6'h2a: func_result = slt_val;
            6'h2b: func_result = sltu_val;
            default: func_result = a + b;
        endcase
    end

    always_comb begin
        case (aluop)
            alu_pass_b: alu_result = b;
            alu_func:   alu_result = func_result;
            alu_pass_a: alu_result = a;
            alu_and:    alu_result = a & b;
            alu_or:     alu_result = a | b;
            alu_xor:    alu_result = a ^ b;
            alu_slt:    alu_result = slt_val;
            alu_sltu:   alu_result = sltu_val;
            default:    alu_result = a + b;
        endcase

        case (aluop)
            alu_eq:  cond = (a == b);
            alu_ne:  cond = (a != b);
            alu_gez: cond = !a[W-1];
            alu_ltz: cond = a[W-1];
            alu_gtz: cond = !a[W-1] && (a != '0);
            alu_lez: cond = a[W-1] || (a == '0);
            default: cond = 1'b0;
        endcase
    end

endmodule

// ==== verilog/mips_cpu_regfile.sv ====
`timescale 1ns/100ps
`include "mips_cpu_params.svh"

module mips_cpu_regfile (
    input  logic                                clk,
    input  logic                                rst,
    input  logic [$clog2(`MIPS_REG_COUNT)-1:0]  raddr_a,
    input  logic [$clog2(`MIPS_REG_COUNT)-1:0]  raddr_b,
    input  logic [$clog2(`MIPS_REG_COUNT)-1:0]  waddr,
    input  logic [`MIPS_DATA_WIDTH-1:0]         wdata,
    input  logic                                wen,
    output logic [`MIPS_DATA_WIDTH-1:0]         rdata_a,
    output logic [`MIPS_DATA_WIDTH-1:0]         rdata_b
);

    logic [`MIPS_DATA_WIDTH-1:0] regs [`MIPS_REG_COUNT];

    assign rdata_a = (raddr_a == '0) ? '0 : regs[raddr_a];
    assign rdata_b = (raddr_b == '0) ? '0 : regs[raddr_b];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `MIPS_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wen && waddr != '0) begin   // $zero is hardwired
            regs[waddr] <= wdata;
        end
    end

endmodule

// ==== verilog/mips_cpu.sv ====
`timescale 1ns/100ps
`include "mips_cpu_params.svh"

module mips_cpu (
    input  logic                        clk,
    input  logic                        rst,
    output logic [`MIPS_DATA_WIDTH-1:0] address,
    output logic                        read,
    output logic                        write,
    output logic [`MIPS_DATA_WIDTH-1:0] writedata,
    output logic [3:0]                  byteenable,
    input  logic [`MIPS_DATA_WIDTH-1:0] readdata,
    input  logic                        waitrequest,
    output logic                        active
);
    import mips_cpu_pkg::*;

    localparam int W = `MIPS_DATA_WIDTH;

    state_t       state;
    aluop_t       aluop;
    logic [1:0]   regdst;
    logic [1:0]   loadtype;
    logic [1:0]   pcsource;
    logic [2:0]   alusrcb;
    logic         regwrite;
    logic         iord;
    logic         irwrite;
    logic         pcwrite;
    logic         pcwritecond;
    logic         jump;
    logic         jumpconen;
    logic         memread;
    logic         memwrite;
    logic         memtoreg;
    logic         hilowrite;
    logic         alusrca;
    logic         aluouten;
    logic         two_cycle;
    logic         cond;
    logic         mem_stall;
    logic         take_target;
    logic         target_pending;
    logic [W-1:0] pc;
    logic [W-1:0] target;
    logic [W-1:0] ir;
    logic [W-1:0] aluout;
    logic [W-1:0] mdr;
    logic [W-1:0] hi;
    logic [W-1:0] lo;
    logic [W-1:0] rs_val;
    logic [W-1:0] rt_val;
    logic [W-1:0] imm_sext;
    logic [W-1:0] alu_a;
    logic [W-1:0] alu_b;
    logic [W-1:0] alu_result;
    logic [W-1:0] pc_next;
    logic [W-1:0] load_value;
    logic [W-1:0] wr_data;
    logic [4:0]   wr_addr;
    logic [7:0]   load_byte;
    logic [15:0]  load_half;

    // Stall only counts while this core has a request on the bus
    assign mem_stall = waitrequest && (memread || memwrite);
    assign take_target = jump || (pcwritecond && cond);

    assign address = iord ? alu_result : pc;
    assign read = memread;
    assign write = memwrite;
    assign active = (state != s_halted);

    assign imm_sext = {{(W-16){ir[15]}}, ir[15:0]};
    assign alu_a = alusrca ? rs_val : pc;

    always_comb begin
        case (alusrcb)
            3'd0: alu_b = rt_val;
            3'd1: alu_b = W'(4);
            3'd2: alu_b = imm_sext;
            3'd3: alu_b = {imm_sext[W-3:0], 2'b00};
            3'd4: alu_b = {{(W-16){1'b0}}, ir[15:0]};
            default: alu_b = ir[1] ? lo : hi;   // MFLO has fncode bit 1 set
        endcase

        case (pcsource)
            2'd0: pc_next = alu_result;
            2'd1: pc_next = aluout;
            2'd2: pc_next = {pc[W-1:W-4], ir[25:0], 2'b00};
            default: pc_next = rs_val;
        endcase

        case (regdst)
            2'd0: wr_addr = ir[20:16];
            2'd1: wr_addr = ir[15:11];
            default: wr_addr = 5'd31;
        endcase
    end

    // Load lanes picked by the address kept in ALUOut
    assign load_byte = mdr[8*aluout[1:0] +: 8];
    assign load_half = aluout[1] ? mdr[31:16] : mdr[15:0];

    always_comb begin
        case (ir[27:26])
            2'b00: load_value = {{(W-8){loadtype[0] & load_byte[7]}}, load_byte};
            2'b01: load_value = {{(W-16){loadtype[0] & load_half[15]}}, load_half};
            default: load_value = mdr;
        endcase

        if (loadtype == 2'd2) begin
            wr_data = {ir[15:0], 16'h0000};   // LUI
        end else if (memtoreg) begin
            wr_data = load_value;
        end else begin
            wr_data = alu_result;
        end

        case (ir[27:26])
            2'b00: writedata = {4{rt_val[7:0]}};
            2'b01: writedata = {2{rt_val[15:0]}};
            default: writedata = rt_val;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= `MIPS_RESET_VECTOR;
            target_pending <= 1'b0;
        end else begin
            if (pcwrite) begin
                pc <= (jumpconen && target_pending) ? target : pc_next;
            end
            if (take_target) begin
                target_pending <= 1'b1;   // Taken after the delay slot
            end else if (jumpconen) begin
                target_pending <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take_target) begin
            target <= pc_next;
        end
        if (irwrite && !mem_stall) begin
            ir <= readdata;
        end
        if (aluouten && !mem_stall) begin
            aluout <= alu_result;
        end
        if (memread && iord && !mem_stall) begin
            mdr <= readdata;
        end
        if (hilowrite && ir[5:0] != 6'h13) begin
            hi <= alu_result;
        end
        if (hilowrite && ir[5:0] != 6'h11) begin
            lo <= alu_result;
        end
    end

    mips_cpu_sequencer u_sequencer (
        .clk         (clk),
        .rst         (rst),
        .waitrequest (mem_stall),
        .two_cycle   (two_cycle),
        .pc_zero     (pc == '0),
        .state       (state)
    );

    mips_cpu_controller u_controller (
        .opcode       (ir[31:26]),
        .fncode       (ir[5:0]),
        .regimm       (ir[20:16]),
        .memoryadress (alu_result[1:0]),
        .state        (state),
        .waitrequest  (mem_stall),
        .regdst       (regdst),
        .loadtype     (loadtype),
        .regwrite     (regwrite),
        .iord         (iord),
        .irwrite      (irwrite),
        .pcwrite      (pcwrite),
        .pcsource     (pcsource),
        .pcwritecond  (pcwritecond),
        .jump         (jump),
        .jumpconen    (jumpconen),
        .memread      (memread),
        .memwrite     (memwrite),
        .byteenable   (byteenable),
        .memtoreg     (memtoreg),
        .aluop        (aluop),
        .hilowrite    (hilowrite),
        .alusrca      (alusrca),
        .alusrcb      (alusrcb),
        .aluouten     (aluouten),
        .two_cycle    (two_cycle)
    );

    mips_cpu_alu u_alu (
        .a          (alu_a),
        .b          (alu_b),
        .shamt      (ir[10:6]),
        .fncode     (ir[5:0]),
        .aluop      (aluop),
        .alu_result (alu_result),
        .cond       (cond)
    );

    mips_cpu_regfile u_regfile (
        .clk     (clk),
        .rst     (rst),
        .raddr_a (ir[25:21]),
        .raddr_b (ir[20:16]),
        .waddr   (wr_addr),
        .wdata   (wr_data),
        .wen     (regwrite),
        .rdata_a (rs_val),
        .rdata_b (rt_val)
    );

endmodule

// ==== dv/mips_cpu_checker.sv ====
`timescale 1ns/100ps

module mips_cpu_checker (
    input logic       clk,
    input logic       rst,
    input logic       read,
    input logic       write,
    input logic [3:0] byteenable,
    input logic       active
);

    int error_count = 0;

    rw_exclusive: assert property (@(posedge clk) disable iff (rst) !(read && write))
        else begin
            $error("read and write are high in the same cycle");
            error_count++;
        end

    write_has_lanes: assert property (@(posedge clk) disable iff (rst)
        write |-> byteenable != 4'b0000)
        else begin
            $error("write with no byte lane enabled");
            error_count++;
        end

    // Halted core stays off the bus
    idle_when_halted: assert property (@(posedge clk) disable iff (rst)
        !active |-> !read && !write)
        else begin
            $error("bus request while the core is halted");
            error_count++;
        end

endmodule

bind mips_cpu mips_cpu_checker u_checker (
    .clk        (clk),
    .rst        (rst),
    .read       (read),
    .write      (write),
    .byteenable (byteenable),
    .active     (active)
);

// ==== dv/mips_cpu_monitor.sv ====
`timescale 1ns/100ps

module mips_cpu_monitor (
    input  logic        clk,
    input  logic        rst,
    input  logic [31:0] address,
    input  logic        write,
    input  logic [31:0] writedata,
    input  logic [3:0]  byteenable,
    input  logic        waitrequest,
    input  logic        active,
    input  logic [31:0] stim [512],
    output logic        done,
    output int          fail_count
);

    localparam int RECORD_BASE = 256;
    localparam int HALT_WAIT = 8;   // Idle cycles watched after halt

    int          record_idx;
    int          halt_cycles;
    logic [31:0] exp_addr;
    logic [31:0] exp_data;
    logic [31:0] exp_be;

    assign exp_addr = stim[RECORD_BASE + 3*record_idx];
    assign exp_data = stim[RECORD_BASE + 3*record_idx + 1];
    assign exp_be = stim[RECORD_BASE + 3*record_idx + 2];

    always @(posedge clk) begin
        int errs;

        errs = 0;
        if (rst) begin
            record_idx <= 0;
            halt_cycles <= 0;
            done <= 1'b0;
            fail_count <= 0;
        end else if (!done) begin
            if (write && !waitrequest) begin
                if (exp_addr === 32'hFFFF_FFFF) begin
                    $display("Store to %h came after the last expected record", address);
                    errs++;
                end else begin
                    if (address !== exp_addr) begin
                        $display("Fail address in store %0d: expected %h, got %h",
                                 record_idx, exp_addr, address);
                        errs++;
                    end
                    if (writedata !== exp_data) begin
                        $display("Fail writedata in store %0d: expected %h, got %h",
                                 record_idx, exp_data, writedata);
                        errs++;
                    end
                    if (byteenable !== exp_be[3:0]) begin
                        $display("Fail byteenable in store %0d: expected %h, got %h",
                                 record_idx, exp_be[3:0], byteenable);
                        errs++;
                    end
                    if (errs == 0) begin
                        $display("Store %0d ok: address %h data %h byteenable %h",
                                 record_idx, address, writedata, byteenable);
                    end
                end
                record_idx <= record_idx + 1;
            end
            if (!active) begin
                if (halt_cycles == 0) begin
                    if (exp_addr !== 32'hFFFF_FFFF) begin
                        $display("Core halted after %0d stores, before all expected stores",
                                 record_idx);
                        errs++;
                    end else begin
                        $display("Halt ok after %0d stores", record_idx);
                    end
                end
                halt_cycles <= halt_cycles + 1;
                if (halt_cycles == HALT_WAIT) begin
                    $display("Checked %0d stores, %0d failures", record_idx, fail_count + errs);
                    done <= 1'b1;
                end
            end
            fail_count <= fail_count + errs;
        end
    end

endmodule

// ==== dv/mips_cpu_tb.sv ====
`timescale 1ns/100ps
`include "mips_cpu_params.svh"

module mips_cpu_tb;

    localparam int STIM_WORDS = 512;
    localparam int MEM_WORDS = 256;
    localparam int RECORD_BASE = 256;

    logic                        clk;
    logic                        rst;
    logic [`MIPS_DATA_WIDTH-1:0] address;
    logic                        read;
    logic                        write;
    logic [`MIPS_DATA_WIDTH-1:0] writedata;
    logic [3:0]                  byteenable;
    logic [`MIPS_DATA_WIDTH-1:0] readdata;
    logic                        waitrequest;
    logic                        active;
    logic                        done;
    int                          fail_count;
    int                          cycle_count;
    int                          cycle_limit;
    logic [31:0]                 stim [STIM_WORDS];
    logic [31:0]                 mem [MEM_WORDS];

    // Data only while a read is requested, upper address bits ignored
    assign readdata = read ? mem[address[9:2]] : 'x;

    mips_cpu uut (
        .clk         (clk),
        .rst         (rst),
        .address     (address),
        .read        (read),
        .write       (write),
        .writedata   (writedata),
        .byteenable  (byteenable),
        .readdata    (readdata),
        .waitrequest (waitrequest),
        .active      (active)
    );

    mips_cpu_monitor u_monitor (
        .clk         (clk),
        .rst         (rst),
        .address     (address),
        .write       (write),
        .writedata   (writedata),
        .byteenable  (byteenable),
        .waitrequest (waitrequest),
        .active      (active),
        .stim        (stim),
        .done        (done),
        .fail_count  (fail_count)
    );

    always #10 clk = ~clk;

    initial begin
        int program_words;

        clk = 1'b0;
        rst = 1'b1;
        waitrequest = 1'b0;
        cycle_count = 0;
        program_words = 0;
        void'($urandom(32'h15d3));
        $readmemh("dv/mips_cpu_stim.hex", stim);
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = stim[i];
        end
        // Count marker holds the program length in its third word
        for (int i = RECORD_BASE; i < STIM_WORDS - 2; i += 3) begin
            if (stim[i] === 32'hFFFF_FFFF) begin
                program_words = stim[i+2];
                break;
            end
        end
        cycle_limit = 8 * program_words * 4;
        if (program_words == 0) begin
            $display("Stim file has no count marker");
            $display("TEST FAIL");
            $finish;
        end else begin
            repeat (4) @(posedge clk);
            rst <= 1'b0;
        end
    end

    // Memory model with random stalls and byte-lane writes
    always @(posedge clk) begin
        if (rst) begin
            waitrequest <= 1'b0;
        end else begin
            waitrequest <= ($urandom % 4) == 0;
        end
        if (write && !waitrequest) begin
            for (int b = 0; b < 4; b++) begin
                if (byteenable[b]) begin
                    mem[address[9:2]][8*b +: 8] <= writedata[8*b +: 8];
                end
            end
        end
    end

    always @(posedge clk) begin
        if (!rst) begin
            cycle_count <= cycle_count + 1;
            if (done) begin
                if (fail_count == 0 && uut.u_checker.error_count == 0) begin
                    $display("TEST PASS");
                end else begin
                    $display("TEST FAIL");
                end
                $finish;
            end else if (cycle_count >= cycle_limit) begin
                $display("Timeout: the core did not halt within %0d cycles", cycle_limit);
                $display("TEST FAIL");
                $finish;
            end
        end
    end

endmodule

// ==== sources.f ====
+incdir+verilog
verilog/mips_cpu_pkg.sv
verilog/mips_cpu_sequencer.sv
verilog/mips_cpu_controller.sv
verilog/mips_cpu_alu.sv
verilog/mips_cpu_regfile.sv
verilog/mips_cpu.sv
dv/mips_cpu_checker.sv
dv/mips_cpu_monitor.sv
dv/mips_cpu_tb.sv

// ==== run.sh ====
#!/bin/bash
set -eo pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f sources.f \
    --top-module mips_cpu_tb -o mips_cpu_sim
./obj_dir/mips_cpu_sim 2>&1 | tee sim.log

if grep -q "TEST FAIL" sim.log; then
    exit 1
fi

// ==== dv/mips_cpu_stim.hex ====
// Words 000-0ff: memory image, program at the reset vector, data word at 0x300
// Words 100 up: expected stores as address, writedata, byteenable; then ffffffff, count, length
@000
// Constants: $2 = 12345678, $1 = 0x200 store base, $3 = -16
3c021234 34425678 24010200 2403fff0 ac220000
// ADDU SUBU AND OR XOR SLT SLTU
00432021 ac240004 00432823 ac250008 00433024 ac26000c 00433825 ac270010
00434026 ac280014 0062482a 0043502b ac290018 ac2a001c
// SLL SRA SRL SLLV SRAV
00025900 ac2b0020 00036103 ac2c0024 00036902 ac2d0028 01227004 ac2e002c
01237807 ac2f0030
// ANDI XORI SLTI
30708f0f ac300034 3851ffff ac310038 2872ffff ac32003c
// LB LBU LH LHU from 0x300
24130300 82740002 ac340040 92750003 ac350044 86760002 ac360048 96770002 ac37004c
// SB and SH at each offset
a0220050 a0220051 a0220052 a0220053 a4220054 a4220056
// Branch, delay-slot store, fall-through store
10420002 ac220058 ac22005c 10430002 ac220060 ac220064
14430002 ac220068 ac22006c 14420002 ac220070 ac220074
18600002 ac220078 ac22007c 18400002 ac220080 ac220084
1c400002 ac220088 ac22008c 1c000002 ac220090 ac220094
04600002 ac220098 ac22009c 04400002 ac2200a0 ac2200a4
04010002 ac2200a8 ac2200ac 04610002 ac2200b0 ac2200b4
04700002 ac3f00b8 ac2200bc 04710002 ac3f00c0 ac2200c4
// MTHI MTLO MFHI MFLO
00400011 00600013 0000c010 0000c812 ac3800c8 ac3900cc
// JAL, JALR, then JR $0 to halt
0ff0006a ac2200d0 3c19bfc0 373901b4 0320d009 ac2200d4 00000008 ac2200d8
// Subroutines at 0x1a8 and 0x1b4
ac3f00dc 03e00008 ac2200e0 ac3a00e4 03400008 ac2200e8
@0c0
80f17f01
@100
00000200 12345678 f  00000204 12345668 f
00000208 12345688 f  0000020c 12345670 f
00000210 fffffff8 f  00000214 edcba988 f
00000218 00000001 f  0000021c 00000001 f
00000220 23456780 f  00000224 ffffffff f
00000228 0fffffff f  0000022c 2468acf0 f
00000230 fffffff8 f  00000234 00008f00 f
00000238 1234a987 f  0000023c 00000001 f
00000240 fffffff1 f  00000244 00000080 f
00000248 ffff80f1 f  0000024c 000080f1 f
00000250 78787878 1  00000251 78787878 2
00000252 78787878 4  00000253 78787878 8
00000254 56785678 3  00000256 56785678 c
00000258 12345678 f  00000260 12345678 f
00000264 12345678 f  00000268 12345678 f
00000270 12345678 f  00000274 12345678 f
00000278 12345678 f  00000280 12345678 f
00000284 12345678 f  00000288 12345678 f
00000290 12345678 f  00000294 12345678 f
00000298 12345678 f  000002a0 12345678 f
000002a4 12345678 f  000002a8 12345678 f
000002b0 12345678 f  000002b4 12345678 f
000002b8 bfc00160 f  000002c0 bfc0016c f
000002c4 12345678 f  000002c8 12345678 f
000002cc fffffff0 f  000002d0 12345678 f
000002dc bfc00190 f  000002e0 12345678 f
000002d4 12345678 f  000002e4 bfc001a0 f
000002e8 12345678 f  000002d8 12345678 f
ffffffff 00000038 00000070
